// ==== Bender.yml ====
package:
  name: mdu

sources:
  - mdu_pkg.sv
  - mdu_mult_array.sv
  - mdu_mult.sv
  - mdu_div.sv
  - mdu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mdu.sv

// ==== mdu_div.sv ====
// Restoring divider for DIV, DIVU, REM and REMU
// Absolute values, 32 compare/subtract steps, then sign fix on one subtractor
`timescale 1ns/1ns

module mdu_div import mdu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  mdu_req_t req_i,
  input  logic     rsp_ready_i,
  output logic     busy_o,
  output logic     valid_o,
  output mdu_rsp_t rsp_o
);

  div_state_e  state_q;
  div_state_e  state_d;
  logic [4:0]  cnt_q;
  logic [4:0]  cnt_d;

  mdu_op_e     op_q;
  word_t       a_q;
  word_t       b_q;
  word_t       num_q;
  word_t       den_q;
  word_t       rem_q;
  word_t       quo_q;
  word_t       res_q;

  logic        req_div_by_zero;
  logic        req_is_quot;
  logic        is_signed;
  logic        is_quot;
  logic        sign_a;
  logic        sign_b;
  logic        change_sign;
  logic [32:0] add_a;
  logic [32:0] add_b;
  logic [33:0] add_res;
  logic [32:0] trial;
  logic        ge;
  word_t       rem_next;
  word_t       quo_next;

  // Decode on the incoming request for the zero-divisor short path
  assign req_div_by_zero = (req_i.op_b == '0);
  assign req_is_quot     = req_i.op inside {OP_DIV, OP_DIVU};

  assign is_signed = op_q inside {OP_DIV, OP_REM};
  assign is_quot   = op_q inside {OP_DIV, OP_DIVU};
  assign sign_a    = a_q[31] & is_signed;
  assign sign_b    = b_q[31] & is_signed;

  // The zero-divisor path bypasses DS_SIGN, so no quotient sign applies there
  assign change_sign = is_quot ? (sign_a ^ sign_b) : sign_a;

  ////////////////////////////////////////////////////////////////////////////
  // Subtractor
  ////////////////////////////////////////////////////////////////////////////

  // Shift in the next dividend bit
  assign trial = {rem_q, num_q[cnt_q]};

  always_comb begin
    add_a = '0;
    add_b = {1'b0, b_q};
    case (state_q)
      DS_ABS_A: add_b = {1'b0, a_q};
      DS_COMP, DS_LAST: begin
        add_a = trial;
        add_b = {1'b0, den_q};
      end
      DS_SIGN:  add_b = {1'b0, res_q};
      default:  add_b = {1'b0, b_q};
    endcase
  end

  assign add_res  = {1'b0, add_a} - {1'b0, add_b};
  assign ge       = ~add_res[33];
  assign rem_next = ge ? add_res[31:0] : trial[31:0];
  assign quo_next = {quo_q[30:0], ge};

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      DS_IDLE: begin
        if (start_i) begin
          state_d = req_div_by_zero ? DS_FINISH : DS_ABS_A;
        end
      end
      DS_ABS_A: state_d = DS_ABS_B;
      DS_ABS_B: begin
        state_d = DS_COMP;
        cnt_d   = 5'd31;
      end
      DS_COMP: begin
        cnt_d = cnt_q - 5'd1;
        if (cnt_q == 5'd1) begin
          state_d = DS_LAST;
        end
      end
      DS_LAST:  state_d = DS_SIGN;
      DS_SIGN:  state_d = DS_FINISH;
      DS_FINISH: begin
        if (rsp_ready_i) begin
          state_d = DS_IDLE;
        end
      end
      default:  state_d = DS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DS_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    case (state_q)
      DS_IDLE: begin
        if (start_i) begin
          op_q  <= req_i.op;
          a_q   <= req_i.op_a;
          b_q   <= req_i.op_b;
          // Quotient of all ones or the dividend, overwritten unless divisor is zero
          res_q <= req_is_quot ? '1 : req_i.op_a;
        end
      end
      DS_ABS_A: num_q <= sign_a ? add_res[31:0] : a_q;
      DS_ABS_B: begin
        den_q <= sign_b ? add_res[31:0] : b_q;
        rem_q <= '0;
        quo_q <= '0;
      end
      DS_COMP: begin
        rem_q <= rem_next;
        quo_q <= quo_next;
      end
      DS_LAST:  res_q <= is_quot ? quo_next : rem_next;
      DS_SIGN: begin
        if (change_sign) begin
          res_q <= add_res[31:0];
        end
      end
    endcase
  end

  assign busy_o       = (state_q != DS_IDLE);
  assign valid_o      = (state_q == DS_FINISH);
  assign rsp_o.result = res_q;
  assign rsp_o.ov     = 1'b0;

endmodule

// ==== mdu_mult.sv ====
// Multiplier sequencer for MUL, MULH, MULHSU, MULHU and KHM16
// Two 32x16 passes build the 64-bit product, KHM16 finishes in one pass
`timescale 1ns/1ns

module mdu_mult import mdu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  mdu_req_t req_i,
  input  logic     rsp_ready_i,
  output logic     busy_o,
  output logic     valid_o,
  output mdu_rsp_t rsp_o
);

  mult_state_e state_q;
  logic        busy_q;
  logic        valid_q;
  mdu_op_e     op_q;
  word_t       a_q;
  word_t       b_q;
  prod48_t     partial_q;
  mdu_rsp_t    rsp_q;
  mdu_rsp_t    rsp_d;

  logic        is_khm;
  logic        running;
  logic        finish;
  logic        b_upper;
  logic        sign_a;
  logic        sign_b_op;
  logic        sign_b;
  array_mode_e arr_mode;
  lane_prod_t  lanes;
  prod48_t     wide;
  prod48_t     upper_sum;
  dword_t      full_prod;
  word_t       mul_word;
  half_t       khm_lo;
  half_t       khm_hi;
  logic        sat_lo;
  logic        sat_hi;

  assign is_khm  = (op_q == OP_KHM16);
  assign running = busy_q & ~valid_q;
  assign b_upper = (state_q == MS_UPPER);
  assign finish  = running & (b_upper | is_khm);

  // Low half of op_b is always unsigned in the first pass
  assign sign_a    = (op_q != OP_MULHU);
  assign sign_b_op = op_q inside {OP_MUL, OP_MULH, OP_KHM16};
  assign sign_b    = sign_b_op & (b_upper | is_khm);
  assign arr_mode  = is_khm ? ARR_16X16 : ARR_32X16;

  mdu_mult_array u_array (
    .op_a_i    (a_q),
    .op_b_i    (b_q),
    .mode_i    (arr_mode),
    .b_upper_i (b_upper),
    .sign_a_i  (sign_a),
    .sign_b_i  (sign_b),
    .lanes_o   (lanes),
    .wide_o    (wide)
  );

  ////////////////////////////////////////////////////////////////////////////
  // 32x32 combine
  ////////////////////////////////////////////////////////////////////////////

  assign upper_sum = wide + {{16{partial_q[47] & sign_a}}, partial_q[47:16]};
  assign full_prod = {upper_sum, partial_q[15:0]};
  assign mul_word  = (op_q == OP_MUL) ? full_prod[31:0] : full_prod[63:32];

  ////////////////////////////////////////////////////////////////////////////
  // KHM16 Q15 lanes
  ////////////////////////////////////////////////////////////////////////////

  // Only -1.0 times -1.0 leaves the Q15 range
  assign sat_lo = (a_q[15:0] == 16'h8000) & (b_q[15:0] == 16'h8000);
  assign sat_hi = (a_q[31:16] == 16'h8000) & (b_q[31:16] == 16'h8000);
  assign khm_lo = sat_lo ? 16'h7fff : lanes.lo[30:15];
  assign khm_hi = sat_hi ? 16'h7fff : lanes.hi[30:15];

  always_comb begin
    if (is_khm) begin
      rsp_d.result = {khm_hi, khm_lo};
      rsp_d.ov     = sat_lo | sat_hi;
    end else begin
      rsp_d.result = mul_word;
      rsp_d.ov     = 1'b0;
    end
  end

  // Control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MS_LOWER;
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else if (start_i) begin
      state_q <= MS_LOWER;
      busy_q  <= 1'b1;
    end else if (valid_q) begin
      if (rsp_ready_i) begin
        valid_q <= 1'b0;
        busy_q  <= 1'b0;
      end
    end else if (finish) begin
      state_q <= MS_LOWER;
      valid_q <= 1'b1;
    end else if (running) begin
      state_q <= MS_UPPER;
    end
  end

  // Request, partial product and result
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q <= req_i.op;
      a_q  <= req_i.op_a;
      b_q  <= req_i.op_b;
    end
    if (running && !b_upper) begin
      partial_q <= wide;
    end
    if (finish) begin
      rsp_q <= rsp_d;
    end
  end

  assign busy_o  = busy_q;
  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

endmodule

// ==== mdu_mult_array.sv ====
// Array of eight 8x8 signed multipliers
// Gives two 16x16 lane products or one 32x16 product, signed or unsigned
`timescale 1ns/1ns

module mdu_mult_array import mdu_pkg::*; (
  input  word_t       op_a_i,
  input  word_t       op_b_i,
  input  array_mode_e mode_i,
  input  logic        b_upper_i,
  input  logic        sign_a_i,
  input  logic        sign_b_i,
  output lane_prod_t  lanes_o,
  output prod48_t     wide_o
);

  logic              lane_mode;
  half_t             b_sel;
  half_t             b_ker0;
  half_t             b_ker1;
  logic [3:0][7:0]   a_byte;
  logic [3:0][7:0]   b_byte;
  logic [3:0]        a_sign;
  logic [3:0]        b_sign;
  logic [17:0]       pp [2][2][2];
  logic signed [32:0] ker_sum [2];
  logic signed [47:0] wide_sum;

  //////////////////////////////////////////////////////////////////////////
  // Operand steering
  //////////////////////////////////////////////////////////////////////////

  assign lane_mode = (mode_i == ARR_16X16);

  // Wide mode feeds the same op_b half to both kernels
  assign b_sel  = b_upper_i ? op_b_i[31:16] : op_b_i[15:0];
  assign b_ker0 = lane_mode ? op_b_i[15:0]  : b_sel;
  assign b_ker1 = lane_mode ? op_b_i[31:16] : b_sel;

  assign a_byte = op_a_i;
  assign b_byte = {b_ker1, b_ker0};

  // Ninth bit of each byte operand
  // Only the top byte of a signed halfword or word carries a sign
  assign a_sign = {op_a_i[31] & sign_a_i,
                   1'b0,
                   op_a_i[15] & sign_a_i & lane_mode,
                   1'b0};
  assign b_sign = {b_ker1[15] & sign_b_i,
                   1'b0,
                   b_ker0[15] & sign_b_i,
                   1'b0};

  //////////////////////////////////////////////////////////////////////////
  // 9x9 multipliers and 16x16 kernel adders
  //////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : g_kernel
    for (genvar i = 0; i < 2; i++) begin : g_a
      for (genvar j = 0; j < 2; j++) begin : g_b
        assign pp[k][i][j] = $signed({a_sign[2*k+i], a_byte[2*k+i]})
                           * $signed({b_sign[2*k+j], b_byte[2*k+j]});
      end
    end

    // Cross terms sit one byte up, the high term two bytes up
    assign ker_sum[k] = $signed(pp[k][0][0])
                      + ($signed(pp[k][0][1]) <<< 8)
                      + ($signed(pp[k][1][0]) <<< 8)
                      + ($signed(pp[k][1][1]) <<< 16);
  end

  //////////////////////////////////////////////////////////////////////////
  // Results
  //////////////////////////////////////////////////////////////////////////

  assign lanes_o.lo = ker_sum[0][31:0];
  assign lanes_o.hi = ker_sum[1][31:0];

  // Upper kernel holds op_a[31:16] times the op_b half
  assign wide_sum = (ker_sum[1] <<< 16) + ker_sum[0];
  assign wide_o   = wide_sum;

endmodule

// ==== mdu_pkg.sv ====
// Shared types for the multiply/divide unit
// Operation codes, word widths, request/response structs and FSM encodings

package mdu_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [47:0] prod48_t;
  typedef logic [63:0] dword_t;

  //////////////////////////////////////////////////////////////////////////
  // Operations and handshake payloads
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU,
    OP_KHM16
  } mdu_op_e;

  typedef struct packed {
    mdu_op_e op;
    word_t   op_a;
    word_t   op_b;
  } mdu_req_t;

  typedef struct packed {
    word_t result;
    logic  ov;
  } mdu_rsp_t;

  //////////////////////////////////////////////////////////////////////////
  // Multiplier array
  //////////////////////////////////////////////////////////////////////////

  // Two halfword lanes or one 32x16 product
  typedef enum logic {
    ARR_16X16,
    ARR_32X16
  } array_mode_e;

  typedef struct packed {
    word_t hi;
    word_t lo;
  } lane_prod_t;

  //////////////////////////////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    MS_LOWER,
    MS_UPPER
  } mult_state_e;

  typedef enum logic [2:0] {
    DS_IDLE,
    DS_ABS_A,
    DS_ABS_B,
    DS_COMP,
    DS_LAST,
    DS_SIGN,
    DS_FINISH
  } div_state_e;

endpackage

// ==== mdu_top.sv ====
// Multiply/divide unit top level
// Starts the multiplier or the divider and returns the busy unit's response
`timescale 1ns/1ns

module mdu_top import mdu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  mdu_req_t req_i,
  output logic     req_ready_o,
  output logic     rsp_valid_o,
  output mdu_rsp_t rsp_o,
  input  logic     rsp_ready_i
);

  logic     accept;
  logic     is_div_op;
  logic     mult_start;
  logic     div_start;
  logic     mult_busy;
  logic     div_busy;
  logic     mult_valid;
  logic     div_valid;
  mdu_rsp_t mult_rsp;
  mdu_rsp_t div_rsp;

  // One operation in flight
  assign req_ready_o = ~(mult_busy | div_busy);
  assign accept      = req_valid_i & req_ready_o;

  assign is_div_op  = req_i.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign mult_start = accept & ~is_div_op;
  assign div_start  = accept & is_div_op;

  mdu_mult u_mult (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (mult_start),
    .req_i       (req_i),
    .rsp_ready_i (rsp_ready_i),
    .busy_o      (mult_busy),
    .valid_o     (mult_valid),
    .rsp_o       (mult_rsp)
  );

  mdu_div u_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (div_start),
    .req_i       (req_i),
    .rsp_ready_i (rsp_ready_i),
    .busy_o      (div_busy),
    .valid_o     (div_valid),
    .rsp_o       (div_rsp)
  );

  // Response of whichever unit holds the operation
  assign rsp_valid_o = div_busy ? div_valid : mult_valid;
  assign rsp_o       = div_busy ? div_rsp : mult_rsp;

endmodule

// ==== tb.f ====
+incdir+.
mdu_pkg.sv
mdu_mult_array.sv
mdu_mult.sv
mdu_div.sv
mdu_top.sv
tb_mdu.sv

// ==== tb_mdu_model.svh ====
// Reference model for the multiply/divide unit testbench
// RV32M multiply and divide results, Q15 halfword multiply with saturation
`ifndef TB_MDU_MODEL_SVH
`define TB_MDU_MODEL_SVH

// Full 64-bit product, each operand extended by its own signedness
function automatic dword_t full_product(input word_t a, input word_t b,
                                        input logic sa, input logic sb);
  dword_t ea;
  dword_t eb;
  ea = sa ? {{32{a[31]}}, a} : {32'h0, a};
  eb = sb ? {{32{b[31]}}, b} : {32'h0, b};
  return ea * eb;
endfunction

// RISC-V division, including the zero divisor and signed overflow cases
function automatic word_t rv_divide(input mdu_op_e op, input word_t a, input word_t b);
  logic  is_signed;
  logic  want_quot;
  word_t quot;
  word_t rem;
  is_signed = (op == OP_DIV) || (op == OP_REM);
  want_quot = (op == OP_DIV) || (op == OP_DIVU);
  if (b == '0) begin
    quot = '1;
    rem  = a;
  end else if (is_signed && a == 32'h8000_0000 && b == '1) begin
    quot = a;
    rem  = '0;
  end else if (is_signed) begin
    quot = $signed(a) / $signed(b);
    rem  = $signed(a) % $signed(b);
  end else begin
    quot = a / b;
    rem  = a % b;
  end
  return want_quot ? quot : rem;
endfunction

// Q15 product of one lane, -1.0 times -1.0 clips to the largest value
function automatic half_t q15_multiply(input half_t a, input half_t b, output logic sat);
  logic signed [31:0] prod;
  sat  = (a == 16'h8000) && (b == 16'h8000);
  prod = $signed(a) * $signed(b);
  return sat ? 16'h7fff : half_t'(prod >>> 15);
endfunction

`endif

// ==== tb_mdu.sv ====
// Testbench for the multiply/divide unit
// Back-to-back requests with corner and random operands, checked by assertions
`timescale 1ns/1ns

module tb_mdu import mdu_pkg::*; ();

  `include "tb_mdu_model.svh"

  localparam int N_RAND      = 20;
  localparam int N_BP        = 12;
  localparam int N_REQ       = 9 * 25 + 9 * N_RAND + 9 * N_BP + 2;
  localparam int WATCHDOG_NS = (N_REQ * 60 + 20) * 8;

  logic     clk_i;
  logic     rst_ni;
  logic     req_valid_i;
  mdu_req_t req_i;
  logic     req_ready_o;
  logic     rsp_valid_o;
  mdu_rsp_t rsp_o;
  logic     rsp_ready_i;

  mdu_req_t req_q [$];
  mdu_req_t cur_req;
  mdu_rsp_t exp_rsp;
  mdu_rsp_t prev_rsp;
  logic     pending;
  logic     prev_valid;
  logic     prev_ready;
  logic     bp_mode;
  int       exp_lat;
  int       wait_cnt;
  int       rsp_cnt;
  int       value_errs;
  int       proto_errs;
  word_t    rsp_result;
  logic     rsp_ov;

  mdu_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

  assign rsp_result = rsp_o.result;
  assign rsp_ov     = rsp_o.ov;

  ////////////////////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////////////////////

  function automatic mdu_rsp_t expected_response(input mdu_req_t req);
    mdu_rsp_t rsp;
    dword_t   prod;
    logic     sat_lo;
    logic     sat_hi;
    rsp.ov = 1'b0;
    case (req.op)
      OP_MUL: begin
        prod       = full_product(req.op_a, req.op_b, 1'b1, 1'b1);
        rsp.result = prod[31:0];
      end
      OP_MULH: begin
        prod       = full_product(req.op_a, req.op_b, 1'b1, 1'b1);
        rsp.result = prod[63:32];
      end
      OP_MULHSU: begin
        prod       = full_product(req.op_a, req.op_b, 1'b1, 1'b0);
        rsp.result = prod[63:32];
      end
      OP_MULHU: begin
        prod       = full_product(req.op_a, req.op_b, 1'b0, 1'b0);
        rsp.result = prod[63:32];
      end
      OP_KHM16: begin
        rsp.result[15:0]  = q15_multiply(req.op_a[15:0], req.op_b[15:0], sat_lo);
        rsp.result[31:16] = q15_multiply(req.op_a[31:16], req.op_b[31:16], sat_hi);
        rsp.ov            = sat_lo | sat_hi;
      end
      default: rsp.result = rv_divide(req.op, req.op_a, req.op_b);
    endcase
    return rsp;
  endfunction

  // Fixed latency in cycles, 0 where it depends on the operands
  function automatic int response_latency(input mdu_op_e op);
    if (op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) return 2;
    if (op == OP_KHM16) return 1;
    return 0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t corner_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // A corner value one time in four
  function automatic word_t pick_operand();
    if ($urandom_range(3) == 0) return corner_value($urandom_range(4));
    return $urandom();
  endfunction

  task automatic add_corner_requests();
    for (int k = 0; k < 9; k++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          req_q.push_back('{op: mdu_op_e'(k), op_a: corner_value(i), op_b: corner_value(j)});
        end
      end
    end
    // Both KHM16 lanes at -1.0, then only the upper lane
    req_q.push_back('{op: OP_KHM16, op_a: 32'h8000_8000, op_b: 32'h8000_8000});
    req_q.push_back('{op: OP_KHM16, op_a: 32'h8000_1234, op_b: 32'h8000_8000});
  endtask

  task automatic add_random_requests(input int per_op);
    for (int n = 0; n < per_op; n++) begin
      for (int k = 0; k < 9; k++) begin
        req_q.push_back('{op: mdu_op_e'(k), op_a: pick_operand(), op_b: pick_operand()});
      end
    end
  endtask

  // Next request waits with valid high while the unit is busy
  task automatic send_requests();
    mdu_req_t req;
    while (req_q.size() > 0) begin
      req = req_q.pop_front();
      req_valid_i <= 1'b1;
      req_i       <= req;
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic run_phase(input logic with_bp);
    int target;
    target = rsp_cnt + req_q.size();
    bp_mode <= with_bp;
    @(posedge clk_i);
    send_requests();
    while (rsp_cnt < target) @(posedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Response ready, low for random stretches in the back-pressure phase
  initial begin : ready_drive
    int stall;
    stall = 0;
    forever begin
      @(posedge clk_i);
      if (!bp_mode) begin
        rsp_ready_i <= 1'b1;
      end else if (stall > 0) begin
        stall--;
        rsp_ready_i <= 1'b0;
      end else if ($urandom_range(1) == 0) begin
        stall = $urandom_range(8);
        rsp_ready_i <= 1'b0;
      end else begin
        rsp_ready_i <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard and checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending    <= 1'b0;
      prev_valid <= 1'b0;
      prev_ready <= 1'b0;
      exp_lat    <= 0;
      wait_cnt   <= 0;
      rsp_cnt    <= 0;
    end else begin
      prev_valid <= rsp_valid_o;
      prev_ready <= rsp_ready_i;
      prev_rsp   <= rsp_o;
      if (req_valid_i && req_ready_o) begin
        pending  <= 1'b1;
        cur_req  <= req_i;
        exp_rsp  <= expected_response(req_i);
        exp_lat  <= response_latency(req_i.op);
        wait_cnt <= 0;
      end else if (pending && !rsp_valid_o) begin
        wait_cnt <= wait_cnt + 1;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        pending <= 1'b0;
        rsp_cnt <= rsp_cnt + 1;
      end
    end
  end

  check_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (rsp_valid_o && rsp_ready_i) |-> (rsp_o == exp_rsp))
    else begin
      value_errs++;
      $display("ERR %0t: %s a=%h b=%h gave %h ov %b, expected %h ov %b", $time,
               cur_req.op.name(), cur_req.op_a, cur_req.op_b, $sampled(rsp_result),
               $sampled(rsp_ov), exp_rsp.result, exp_rsp.ov);
    end

  check_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_valid_o |-> pending)
    else begin
      proto_errs++;
      $display("At %0t a response appeared with no request in flight", $time);
    end

  check_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (rsp_valid_o && !prev_valid && exp_lat != 0) |-> (wait_cnt == exp_lat))
    else begin
      proto_errs++;
      $display("At %0t the %s response came after %0d cycles instead of %0d", $time,
               cur_req.op.name(), wait_cnt, exp_lat);
    end

  check_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (prev_valid && !prev_ready) |-> (rsp_valid_o && rsp_o == prev_rsp))
    else begin
      proto_errs++;
      $display("At %0t the response changed or dropped while it was stalled", $time);
    end

  check_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pending |-> !req_ready_o)
    else begin
      proto_errs++;
      $display("At %0t the unit was ready for a request while one was in flight", $time);
    end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d of %0d responses", WATCHDOG_NS, rsp_cnt, N_REQ);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    bp_mode     = 1'b0;
    value_errs  = 0;
    proto_errs  = 0;
    void'($urandom(32'h33b8_de22));
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_reset: assert (!rsp_valid_o && req_ready_o)
      else begin
        proto_errs++;
        $display("After reset a response was valid or requests were not accepted");
      end
    add_corner_requests();
    add_random_requests(N_RAND);
    run_phase(1'b0);
    add_random_requests(N_BP);
    run_phase(1'b1);
    repeat (4) @(posedge clk_i);
    $display("Done: %0d responses, %0d value errors, %0d protocol errors",
             rsp_cnt, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
